// ==== udp_rx_pkg.sv ====
package udp_rx_pkg;

    // basic stream and header field types
    typedef logic [7:0]  byte_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] port_t;

    // the udp header occupies the first eight payload bytes
    localparam int UDP_HDR_BYTES = 8;
    localparam int HDR_IDX_W     = 3;

    // frame byte pointer, wide enough for any udp length
    localparam int PTR_W = 16;

    // field order matches the order on the wire
    typedef struct packed {
        port_t source_port;
        port_t dest_port;
        port_t length;
        port_t checksum;
    } udp_hdr_fields_t;

    // octets[0] is the first byte received, i.e. the msb of the source port
    typedef union packed {
        udp_hdr_fields_t                 fields;
        byte_t [0:UDP_HDR_BYTES-1]       octets;
    } udp_hdr_u;

    // frame state machine
    typedef enum logic [1:0] {
        st_idle    = 2'd0,
        st_header  = 2'd1,
        st_payload = 2'd2,
        st_trim    = 2'd3
    } rx_state_t;

endpackage

// ==== udp_hdr_capture.sv ====
module udp_hdr_capture
    import udp_rx_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 store_ip,
    input  ip_addr_t             ip_source_ip,
    input  ip_addr_t             ip_dest_ip,
    input  logic                 hdr_byte_we,
    input  logic [HDR_IDX_W-1:0] hdr_byte_idx,
    input  byte_t                hdr_byte,
    output ip_addr_t             ip_source_ip_out,
    output ip_addr_t             ip_dest_ip_out,
    output udp_hdr_u             udp_hdr,
    output port_t                udp_length
);

    ip_addr_t src_ip_reg;
    ip_addr_t dst_ip_reg;
    udp_hdr_u hdr_reg;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            src_ip_reg <= '0;
            dst_ip_reg <= '0;
            hdr_reg    <= '0;
        end else begin
            // addresses are taken with the ip header handshake
            if (store_ip) begin
                src_ip_reg <= ip_source_ip;
                dst_ip_reg <= ip_dest_ip;
            end
            // one wire byte per strobe, index 0 lands in the source port msb
            if (hdr_byte_we) begin
                hdr_reg.octets[hdr_byte_idx] <= hdr_byte;
            end
        end
    end

    assign ip_source_ip_out = src_ip_reg;
    assign ip_dest_ip_out   = dst_ip_reg;
    assign udp_hdr          = hdr_reg;

    // controller trims the payload against this
    assign udp_length = hdr_reg.fields.length;

endmodule

// ==== udp_payload_skid.sv ====
module udp_payload_skid
    import udp_rx_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  byte_t beat_data,
    input  logic  beat_valid,
    input  logic  beat_last,
    input  logic  beat_user,
    input  logic  tready,
    output logic  ready_early,
    output byte_t tdata,
    output logic  tvalid,
    output logic  tlast,
    output logic  tuser
);

    // second slot, filled only when the output register is stalled
    byte_t temp_data;
    logic  temp_valid;
    logic  temp_last;
    logic  temp_user;

    // ready as the source sees it this cycle
    logic  ready_reg;

    logic  out_valid_next;
    logic  temp_valid_next;
    logic  in_to_out;
    logic  in_to_temp;
    logic  temp_to_out;

    // ready next cycle if the sink drains or the temp slot stays free
    assign ready_early = tready | (~temp_valid & (~tvalid | ~beat_valid));

    always_comb begin
        out_valid_next  = tvalid;
        temp_valid_next = temp_valid;
        in_to_out       = 1'b0;
        in_to_temp      = 1'b0;
        temp_to_out     = 1'b0;
        if (ready_reg) begin
            if (tready || !tvalid) begin
                out_valid_next = beat_valid;
                in_to_out      = 1'b1;
            end else begin
                temp_valid_next = beat_valid;
                in_to_temp      = 1'b1;
            end
        end else if (tready) begin
            out_valid_next  = temp_valid;
            temp_valid_next = 1'b0;
            temp_to_out     = 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ready_reg  <= 1'b0;
            tvalid     <= 1'b0;
            temp_valid <= 1'b0;
        end else begin
            ready_reg  <= ready_early;
            tvalid     <= out_valid_next;
            temp_valid <= temp_valid_next;
        end
    end

    always_ff @(posedge clk) begin
        if (in_to_out) begin
            tdata <= beat_data;
            tlast <= beat_last;
            tuser <= beat_user;
        end else if (temp_to_out) begin
            tdata <= temp_data;
            tlast <= temp_last;
            tuser <= temp_user;
        end
        if (in_to_temp) begin
            temp_data <= beat_data;
            temp_last <= beat_last;
            temp_user <= beat_user;
        end
    end

endmodule

// ==== udp_rx_ctrl.sv ====
module udp_rx_ctrl
    import udp_rx_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 ip_hdr_valid,
    output logic                 ip_hdr_ready,
    input  byte_t                ip_payload_tdata,
    input  logic                 ip_payload_tvalid,
    output logic                 ip_payload_tready,
    input  logic                 ip_payload_tlast,
    input  logic                 ip_payload_tuser,
    output logic                 udp_hdr_valid,
    input  logic                 udp_hdr_ready,
    input  port_t                udp_length,
    output logic                 store_ip,
    output logic                 hdr_byte_we,
    output logic [HDR_IDX_W-1:0] hdr_byte_idx,
    output byte_t                beat_data,
    output logic                 beat_valid,
    output logic                 beat_last,
    output logic                 beat_user,
    input  logic                 ready_early,
    output logic                 busy,
    output logic                 error_header_early_termination,
    output logic                 error_payload_early_termination
);

    rx_state_t        state;
    rx_state_t        state_next;
    logic [PTR_W-1:0] frame_ptr;
    logic [PTR_W-1:0] frame_ptr_next;

    // final kept byte, held while the tail of an over-long frame is dropped
    byte_t            last_word;
    logic             store_last;

    logic             hdr_ready_next;
    logic             tready_next;
    logic             hdr_valid_next;
    logic             err_hdr_next;
    logic             err_pay_next;

    logic             hdr_xfer;
    logic             beat_xfer;

    assign hdr_xfer     = ip_hdr_valid & ip_hdr_ready;
    assign beat_xfer    = ip_payload_tvalid & ip_payload_tready;
    assign hdr_byte_idx = frame_ptr[HDR_IDX_W-1:0];

    always_comb begin
        state_next     = state;
        frame_ptr_next = frame_ptr;
        hdr_ready_next = 1'b0;
        tready_next    = 1'b0;
        // a pending udp header stays up until the sink takes it
        hdr_valid_next = udp_hdr_valid & ~udp_hdr_ready;
        err_hdr_next   = 1'b0;
        err_pay_next   = 1'b0;
        store_ip       = 1'b0;
        hdr_byte_we    = 1'b0;
        store_last     = 1'b0;
        beat_data      = ip_payload_tdata;
        beat_valid     = 1'b0;
        beat_last      = ip_payload_tlast;
        beat_user      = ip_payload_tuser;

        case (state)
            st_idle: begin
                frame_ptr_next = '0;
                hdr_ready_next = ~udp_hdr_valid;
                if (hdr_xfer) begin
                    hdr_ready_next = 1'b0;
                    tready_next    = 1'b1;
                    store_ip       = 1'b1;
                    state_next     = st_header;
                end
            end
            st_header: begin
                tready_next = 1'b1;
                if (beat_xfer) begin
                    hdr_byte_we    = 1'b1;
                    frame_ptr_next = frame_ptr + 1'b1;
                    if (ip_payload_tlast) begin
                        // frame ended inside the udp header
                        err_hdr_next   = 1'b1;
                        hdr_ready_next = ~udp_hdr_valid;
                        tready_next    = 1'b0;
                        state_next     = st_idle;
                    end else if (frame_ptr == PTR_W'(UDP_HDR_BYTES - 1)) begin
                        hdr_valid_next = 1'b1;
                        tready_next    = ready_early;
                        state_next     = st_payload;
                    end
                end
            end
            st_payload: begin
                tready_next = ready_early;
                beat_valid  = beat_xfer;
                if (beat_xfer) begin
                    frame_ptr_next = frame_ptr + 1'b1;
                    if (ip_payload_tlast) begin
                        // short frame, flag it on the last beat
                        if (frame_ptr_next != udp_length) begin
                            beat_user    = 1'b1;
                            err_pay_next = 1'b1;
                        end
                        hdr_ready_next = ~udp_hdr_valid;
                        tready_next    = 1'b0;
                        state_next     = st_idle;
                    end else if (frame_ptr_next == udp_length) begin
                        // length reached before tlast, keep this byte back
                        store_last = 1'b1;
                        beat_valid = 1'b0;
                        state_next = st_trim;
                    end
                end
            end
            st_trim: begin
                tready_next = ready_early;
                beat_data   = last_word;
                beat_valid  = beat_xfer & ip_payload_tlast;
                if (beat_xfer && ip_payload_tlast) begin
                    hdr_ready_next = ~udp_hdr_valid;
                    tready_next    = 1'b0;
                    state_next     = st_idle;
                end
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state                           <= st_idle;
            frame_ptr                       <= '0;
            ip_hdr_ready                    <= 1'b0;
            ip_payload_tready               <= 1'b0;
            udp_hdr_valid                   <= 1'b0;
            busy                            <= 1'b0;
            error_header_early_termination  <= 1'b0;
            error_payload_early_termination <= 1'b0;
        end else begin
            state                           <= state_next;
            frame_ptr                       <= frame_ptr_next;
            ip_hdr_ready                    <= hdr_ready_next;
            ip_payload_tready               <= tready_next;
            udp_hdr_valid                   <= hdr_valid_next;
            busy                            <= (state_next != st_idle);
            error_header_early_termination  <= err_hdr_next;
            error_payload_early_termination <= err_pay_next;
        end
    end

    always_ff @(posedge clk) begin
        if (store_last) begin
            last_word <= ip_payload_tdata;
        end
    end

endmodule

// ==== udp_ip_rx.sv ====
module udp_ip_rx
    import udp_rx_pkg::*;
(
    input  logic     clk,
    input  logic     rst,

    // ip header and payload in
    input  logic     ip_hdr_valid,
    output logic     ip_hdr_ready,
    input  ip_addr_t ip_source_ip,
    input  ip_addr_t ip_dest_ip,
    input  byte_t    ip_payload_tdata,
    input  logic     ip_payload_tvalid,
    output logic     ip_payload_tready,
    input  logic     ip_payload_tlast,
    input  logic     ip_payload_tuser,

    // udp header and payload out
    output logic     udp_hdr_valid,
    input  logic     udp_hdr_ready,
    output ip_addr_t ip_source_ip_out,
    output ip_addr_t ip_dest_ip_out,
    output udp_hdr_u udp_hdr,
    output byte_t    udp_payload_tdata,
    output logic     udp_payload_tvalid,
    input  logic     udp_payload_tready,
    output logic     udp_payload_tlast,
    output logic     udp_payload_tuser,

    // status
    output logic     busy,
    output logic     error_header_early_termination,
    output logic     error_payload_early_termination
);

    // controller to header capture
    logic                 store_ip;
    logic                 hdr_byte_we;
    logic [HDR_IDX_W-1:0] hdr_byte_idx;
    port_t                udp_length;

    // controller to output skid
    byte_t                beat_data;
    logic                 beat_valid;
    logic                 beat_last;
    logic                 beat_user;
    logic                 ready_early;

    udp_rx_ctrl udp_rx_ctrl_i (
        .clk                             (clk),
        .rst                             (rst),
        .ip_hdr_valid                    (ip_hdr_valid),
        .ip_hdr_ready                    (ip_hdr_ready),
        .ip_payload_tdata                (ip_payload_tdata),
        .ip_payload_tvalid               (ip_payload_tvalid),
        .ip_payload_tready               (ip_payload_tready),
        .ip_payload_tlast                (ip_payload_tlast),
        .ip_payload_tuser                (ip_payload_tuser),
        .udp_hdr_valid                   (udp_hdr_valid),
        .udp_hdr_ready                   (udp_hdr_ready),
        .udp_length                      (udp_length),
        .store_ip                        (store_ip),
        .hdr_byte_we                     (hdr_byte_we),
        .hdr_byte_idx                    (hdr_byte_idx),
        .beat_data                       (beat_data),
        .beat_valid                      (beat_valid),
        .beat_last                       (beat_last),
        .beat_user                       (beat_user),
        .ready_early                     (ready_early),
        .busy                            (busy),
        .error_header_early_termination  (error_header_early_termination),
        .error_payload_early_termination (error_payload_early_termination)
    );

    udp_hdr_capture udp_hdr_capture_i (
        .clk              (clk),
        .rst              (rst),
        .store_ip         (store_ip),
        .ip_source_ip     (ip_source_ip),
        .ip_dest_ip       (ip_dest_ip),
        .hdr_byte_we      (hdr_byte_we),
        .hdr_byte_idx     (hdr_byte_idx),
        .hdr_byte         (ip_payload_tdata),
        .ip_source_ip_out (ip_source_ip_out),
        .ip_dest_ip_out   (ip_dest_ip_out),
        .udp_hdr          (udp_hdr),
        .udp_length       (udp_length)
    );

    udp_payload_skid udp_payload_skid_i (
        .clk         (clk),
        .rst         (rst),
        .beat_data   (beat_data),
        .beat_valid  (beat_valid),
        .beat_last   (beat_last),
        .beat_user   (beat_user),
        .tready      (udp_payload_tready),
        .ready_early (ready_early),
        .tdata       (udp_payload_tdata),
        .tvalid      (udp_payload_tvalid),
        .tlast       (udp_payload_tlast),
        .tuser       (udp_payload_tuser)
    );

endmodule

// ==== udp_ip_rx_chk.sv ====
module udp_ip_rx_chk
    import udp_rx_pkg::*;
(
    input logic  clk,
    input logic  rst,
    input byte_t udp_payload_tdata,
    input logic  udp_payload_tvalid,
    input logic  udp_payload_tready,
    input logic  udp_payload_tlast,
    input logic  udp_payload_tuser,
    input logic  ip_hdr_ready,
    input logic  ip_payload_tready,
    input logic  error_header_early_termination,
    input logic  error_payload_early_termination
);
    timeunit 1ns;
    timeprecision 1ps;

    // a stalled beat must hold until the sink takes it
    assert property (@(posedge clk) disable iff (rst)
        (udp_payload_tvalid && !udp_payload_tready) |=>
            (udp_payload_tvalid && $stable(udp_payload_tdata)
             && $stable(udp_payload_tlast) && $stable(udp_payload_tuser)))
        else $error("payload output changed while stalled");

    assert property (@(posedge clk) disable iff (rst)
        !(ip_hdr_ready && ip_payload_tready))
        else $error("header ready and payload ready high together");

    assert property (@(posedge clk) disable iff (rst)
        !(error_header_early_termination && error_payload_early_termination))
        else $error("both error flags high together");

    // each error is a one-cycle pulse
    assert property (@(posedge clk) disable iff (rst)
        error_header_early_termination |=> !error_header_early_termination)
        else $error("header error longer than one cycle");

    assert property (@(posedge clk) disable iff (rst)
        error_payload_early_termination |=> !error_payload_early_termination)
        else $error("payload error longer than one cycle");

endmodule

bind udp_ip_rx udp_ip_rx_chk udp_ip_rx_chk_i (.*);

// ==== udp_ip_rx_tb.sv ====
module udp_ip_rx_tb
    import udp_rx_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_CASES = 32;
    localparam int COLS      = 9;

    logic     clk;
    logic     rst;
    logic     ip_hdr_valid;
    logic     ip_hdr_ready;
    ip_addr_t ip_source_ip;
    ip_addr_t ip_dest_ip;
    byte_t    ip_payload_tdata;
    logic     ip_payload_tvalid;
    logic     ip_payload_tready;
    logic     ip_payload_tlast;
    logic     ip_payload_tuser;
    logic     udp_hdr_valid;
    logic     udp_hdr_ready;
    ip_addr_t ip_source_ip_out;
    ip_addr_t ip_dest_ip_out;
    udp_hdr_u udp_hdr;
    byte_t    udp_payload_tdata;
    logic     udp_payload_tvalid;
    logic     udp_payload_tready;
    logic     udp_payload_tlast;
    logic     udp_payload_tuser;
    logic     busy;
    logic     error_header_early_termination;
    logic     error_payload_early_termination;

    logic [31:0] cases_mem [0:MAX_CASES*COLS-1];
    logic [31:0] lcg_state;
    // separate lcg stream for the sink side
    logic [31:0] sink_state;
    logic [31:0] bp_rnd;
    logic [3:0]  cur_mode;
    int          num_cases;
    int          watchdog_cycles;
    int          exp_err_h;
    int          exp_err_p;
    int          got_err_h;
    int          got_err_p;

    // expected output, in order
    udp_hdr_u exp_hdr_q[$];
    ip_addr_t exp_src_q[$];
    ip_addr_t exp_dst_q[$];
    byte_t    exp_data_q[$];
    logic     exp_last_q[$];
    logic     exp_user_q[$];

    udp_ip_rx udp_ip_rx_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] next_rand(inout logic [31:0] state);
        state = state * 32'd1664525 + 32'd1013904223;
        return state;
    endfunction

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_hdr(input udp_hdr_u got, input udp_hdr_u exp,
                             input ip_addr_t got_src, input ip_addr_t exp_src,
                             input ip_addr_t got_dst, input ip_addr_t exp_dst);
        if (got !== exp) begin
            $display("MISMATCH t=%0t udp_hdr got %h expected %h", $time, got, exp);
            fail_now("udp header fields wrong");
        end
        if (got_src !== exp_src) begin
            $display("MISMATCH t=%0t ip_source_ip_out got %h expected %h",
                     $time, got_src, exp_src);
            fail_now("source address wrong");
        end
        if (got_dst !== exp_dst) begin
            $display("MISMATCH t=%0t ip_dest_ip_out got %h expected %h",
                     $time, got_dst, exp_dst);
            fail_now("destination address wrong");
        end
    endtask

    task automatic check_byte(input byte_t got, input byte_t exp,
                              input logic got_last, input logic exp_last,
                              input logic got_user, input logic exp_user);
        if (got !== exp || got_last !== exp_last || got_user !== exp_user) begin
            $display({"MISMATCH t=%0t udp_payload_tdata/tlast/tuser",
                      " got %h/%b/%b expected %h/%b/%b"},
                     $time, got, got_last, got_user, exp, exp_last, exp_user);
            fail_now("payload beat wrong");
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH t=%0t %s got %b expected %b", $time, name, got, exp);
            fail_now("status flag wrong");
        end
    endtask

    // sink side back-pressure
    always @(posedge clk) begin
        bp_rnd = next_rand(sink_state);
        udp_payload_tready <= cur_mode[1] ? bp_rnd[20] : 1'b1;
        udp_hdr_ready      <= cur_mode[2] ? (bp_rnd[27:25] == 3'd0) : 1'b1;
    end

    // scoreboard
    always @(posedge clk) begin
        if (!rst) begin
            if (udp_hdr_valid && udp_hdr_ready) begin
                if (exp_hdr_q.size() == 0)
                    fail_now("udp header came out with none expected");
                else
                    check_hdr(udp_hdr, exp_hdr_q.pop_front(), ip_source_ip_out,
                              exp_src_q.pop_front(), ip_dest_ip_out, exp_dst_q.pop_front());
            end
            if (udp_payload_tvalid && udp_payload_tready) begin
                if (exp_data_q.size() == 0)
                    fail_now("extra payload beat came out");
                else
                    check_byte(udp_payload_tdata, exp_data_q.pop_front(), udp_payload_tlast,
                               exp_last_q.pop_front(), udp_payload_tuser,
                               exp_user_q.pop_front());
            end
            if (error_header_early_termination)
                got_err_h++;
            if (error_payload_early_termination)
                got_err_p++;
        end
    end

    task automatic send_frame(input int c);
        ip_addr_t src;
        ip_addr_t dst;
        udp_hdr_u hdr;
        int       n;
        int       len;
        int       keep;
        int       total;
        logic     fin_user;
        logic     short_frame;
        logic [3:0] mode;
        logic [31:0] r;
        byte_t    stream[$];

        src                   = cases_mem[c*COLS];
        dst                   = cases_mem[c*COLS+1];
        hdr.fields.source_port = cases_mem[c*COLS+2][15:0];
        hdr.fields.dest_port   = cases_mem[c*COLS+3][15:0];
        hdr.fields.length      = cases_mem[c*COLS+4][15:0];
        hdr.fields.checksum    = cases_mem[c*COLS+5][15:0];
        n        = cases_mem[c*COLS+6];
        fin_user = cases_mem[c*COLS+7][0];
        mode     = cases_mem[c*COLS+8][3:0];
        len      = int'(hdr.fields.length);
        cur_mode <= mode;

        // header bytes go out in wire order
        for (int i = 0; i < UDP_HDR_BYTES; i++)
            stream.push_back(hdr.octets[i]);
        if (mode[3]) begin
            total = n;
        end else begin
            for (int i = 0; i < n; i++) begin
                r = next_rand(lcg_state);
                stream.push_back(r[15:8]);
            end
            total = UDP_HDR_BYTES + n;
        end

        short_frame = !mode[3] && (n < len - 8);
        if (mode[3]) begin
            exp_err_h++;
        end else begin
            keep = short_frame ? n : len - 8;
            for (int i = 0; i < keep; i++) begin
                exp_data_q.push_back(stream[UDP_HDR_BYTES+i]);
                exp_last_q.push_back(i == keep - 1);
                exp_user_q.push_back((i == keep - 1) ? (short_frame | fin_user) : 1'b0);
            end
            exp_hdr_q.push_back(hdr);
            exp_src_q.push_back(src);
            exp_dst_q.push_back(dst);
            if (short_frame)
                exp_err_p++;
        end

        ip_source_ip <= src;
        ip_dest_ip   <= dst;
        ip_hdr_valid <= 1'b1;
        do @(posedge clk); while (!ip_hdr_ready);
        ip_hdr_valid <= 1'b0;

        for (int i = 0; i < total; i++) begin
            if (mode[0]) begin
                r = next_rand(lcg_state);
                if (r[22:21] == 2'd0) begin
                    ip_payload_tvalid <= 1'b0;
                    @(posedge clk);
                end
            end
            ip_payload_tdata  <= stream[i];
            ip_payload_tvalid <= 1'b1;
            ip_payload_tlast  <= (i == total - 1);
            ip_payload_tuser  <= (i == total - 1) ? fin_user : 1'b0;
            do @(posedge clk); while (!ip_payload_tready);
            check_flag("busy", busy, 1'b1);
        end
        ip_payload_tvalid <= 1'b0;
        ip_payload_tlast  <= 1'b0;
        ip_payload_tuser  <= 1'b0;

        // error flags are registered on the tlast edge
        @(posedge clk);
        check_flag("error_header_early_termination", error_header_early_termination, mode[3]);
        check_flag("error_payload_early_termination", error_payload_early_termination,
                   short_frame);
    endtask

    initial begin
        watchdog_cycles = 0;
        wait (watchdog_cycles != 0);
        repeat (watchdog_cycles) @(posedge clk);
        fail_now($sformatf("timeout after %0d cycles, %0d beats and %0d headers still expected",
                           watchdog_cycles, exp_data_q.size(), exp_hdr_q.size()));
    end

    initial begin
        int limit;

        rst               = 1'b1;
        ip_hdr_valid      = 1'b0;
        ip_source_ip      = '0;
        ip_dest_ip        = '0;
        ip_payload_tdata  = '0;
        ip_payload_tvalid = 1'b0;
        ip_payload_tlast  = 1'b0;
        ip_payload_tuser  = 1'b0;
        udp_hdr_ready     = 1'b0;
        udp_payload_tready = 1'b0;
        lcg_state  = 32'h1bc1_5932;
        sink_state = 32'h1bc1_5932;
        cur_mode   = 4'd0;
        exp_err_h = 0;
        exp_err_p = 0;
        got_err_h = 0;
        got_err_p = 0;
        for (int i = 0; i < MAX_CASES * COLS; i++)
            cases_mem[i] = '0;
        $readmemh("udp_rx_cases.txt", cases_mem);

        // a zero udp length ends the table
        limit     = 16;
        num_cases = 0;
        while (num_cases < MAX_CASES && cases_mem[num_cases*COLS+4] != 0) begin
            limit += (cases_mem[num_cases*COLS+6] + 16) * 4;
            num_cases++;
        end
        if (num_cases == 0)
            fail_now("no frames found in udp_rx_cases.txt");
        watchdog_cycles = limit;

        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_flag("busy", busy, 1'b0);
        check_flag("error_header_early_termination", error_header_early_termination, 1'b0);
        check_flag("error_payload_early_termination", error_payload_early_termination, 1'b0);

        for (int c = 0; c < num_cases; c++)
            send_frame(c);

        cur_mode <= 4'd0;
        while (exp_data_q.size() != 0 || exp_hdr_q.size() != 0)
            @(posedge clk);
        repeat (4) @(posedge clk);

        if (got_err_h == exp_err_h && got_err_p == exp_err_p) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            fail_now($sformatf("error pulse counts %0d/%0d, expected %0d/%0d",
                               got_err_h, got_err_p, exp_err_h, exp_err_p));
        end
    end

endmodule

// ==== udp_rx_cases.txt ====
// src_ip dst_ip src_port dst_port udp_length checksum n final_tuser mode
// mode bits: 0 input gaps, 1 payload tready drops, 2 slow header ready, 3 frame ends in header
c0a80001 c0a80002 1234 5678 0014 abcd 0000000c 0 0
0a000001 0a0000fe 0035 c001 0010 0f0f 00000014 1 0
ac100005 ac100009 1000 2000 0020 5555 0000000a 0 0
c0a80101 c0a80102 4321 8765 0018 0000 00000005 0 8
c0a80103 c0a80104 0bad 0cab 000d 1111 00000005 0 0
0a0a0a0a 0b0b0b0b 2710 2711 0040 7e7e 00000038 0 7
01020304 05060708 abcd ef01 0030 9999 00000050 1 6
08080808 09090909 0101 0202 0040 3c3c 00000010 0 3
7f000001 7f000002 ffff 0001 0009 aaaa 00000001 1 2

// ==== udp_ip_rx.f ====
udp_rx_pkg.sv
udp_hdr_capture.sv
udp_payload_skid.sv
udp_rx_ctrl.sv
udp_ip_rx.sv
udp_ip_rx_chk.sv
udp_ip_rx_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module udp_ip_rx_tb \
    -f udp_ip_rx.f -o udp_ip_rx_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/udp_ip_rx_sim > sim.log 2>&1
cat sim.log

grep -q "Result: FAILED" sim.log && exit 1
grep -q "Result: PASSED" sim.log && exit 0 || exit 1
